//--- common/ahb_pkg.sv
// AHB-lite encodings and bus widths, referenced by scoped name from the slave, top and testbench
`default_nettype none

package ahb_pkg;

    // ------------------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------------------

    // Byte address, word aligned accesses only
    localparam int unsigned HADDR_WIDTH = 32;
    // Read and write data buses
    localparam int unsigned HDATA_WIDTH = 32;

    // ------------------------------------------------------------------------
    // Transfer type and response
    // ------------------------------------------------------------------------

    // HTRANS encoding from the AHB-lite specification
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    // Only OKAY is ever returned by this slave
    localparam logic HRESP_OKAY = 1'b0;

    // Address and data words on the bus
    typedef logic [HADDR_WIDTH-1:0] haddr_t;
    typedef logic [HDATA_WIDTH-1:0] hdata_t;

endpackage

`default_nettype wire

//--- common/pmu_pkg.sv
// PMU register map, configuration word layout and SEC-DED helpers shared by the PMU blocks
`default_nettype none

package pmu_pkg;

    // ------------------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------------------

    localparam int unsigned WORD_BITS = 32;
    typedef logic [WORD_BITS-1:0] word_t;

    // Configuration word sits first, counters follow
    localparam int unsigned REG_CFG      = 0;
    localparam int unsigned REG_CNT_BASE = 1;
    // Overflow status comes right after the last counter, derived per module

    // Configuration fields, enable in bit 0
    typedef struct packed {
        logic [29:0] reserved;
        logic        soft_rst;
        logic        enable;
    } pmu_cfg_t;

    // Bus sees the raw word, the counter core sees the fields
    typedef union packed {
        word_t    raw;
        pmu_cfg_t cfg;
    } pmu_cfg_u;

    // ------------------------------------------------------------------------
    // SEC-DED code
    // ------------------------------------------------------------------------

    // Six Hamming bits at the power-of-two positions plus overall parity in bit 0
    localparam int unsigned ECC_BITS  = 7;
    localparam int unsigned CODE_BITS = WORD_BITS + ECC_BITS;
    typedef logic [CODE_BITS-1:0] code_t;

    function automatic code_t ecc_encode(input word_t data);
        code_t       cw;
        int unsigned di;
        cw = '0;
        di = 0;
        // Data fills every position that is not a power of two
        for (int unsigned p = 1; p < CODE_BITS; p++) begin
            if ((p & (p - 1)) != 0) begin
                cw[p] = data[di];
                di++;
            end
        end
        // Check bit b covers all positions with bit b of the index set
        for (int unsigned b = 0; b < ECC_BITS - 1; b++) begin
            for (int unsigned p = 1; p < CODE_BITS; p++) begin
                if ((((p >> b) & 1) != 0) && (p != (1 << b))) begin
                    cw[1 << b] = cw[1 << b] ^ cw[p];
                end
            end
        end
        // Overall parity makes the whole codeword even
        cw[0] = ^cw[CODE_BITS-1:1];
        return cw;
    endfunction

    function automatic word_t ecc_decode(input code_t cw, output logic sec, output logic ded);
        logic [ECC_BITS-2:0] syn;
        logic                par;
        code_t               fixed;
        word_t               data;
        int unsigned         di;
        syn = '0;
        for (int unsigned b = 0; b < ECC_BITS - 1; b++) begin
            for (int unsigned p = 1; p < CODE_BITS; p++) begin
                if (((p >> b) & 1) != 0) begin
                    syn[b] = syn[b] ^ cw[p];
                end
            end
        end
        par   = ^cw;
        fixed = cw;
        sec   = 1'b0;
        ded   = 1'b0;
        if (par) begin
            // Odd parity, one flipped bit; syndrome 0 points at the parity bit
            if (syn < CODE_BITS) begin
                fixed[syn] = ~fixed[syn];
                sec        = 1'b1;
            end else begin
                // Syndrome past the codeword, more than one bit gone
                ded = 1'b1;
            end
        end else if (syn != '0) begin
            ded = 1'b1;
        end
        // Gather the data positions back into a word
        data = '0;
        di   = 0;
        for (int unsigned p = 1; p < CODE_BITS; p++) begin
            if ((p & (p - 1)) != 0) begin
                data[di] = fixed[p];
                di++;
            end
        end
        return data;
    endfunction

endpackage

`default_nettype wire

//--- hw/ahb_slave/pmu_ahb_slave.sv
// AHB-lite slave of the PMU: captures the address phase and drives register strobes and read data
`default_nettype none

module pmu_ahb_slave #(
    parameter  int unsigned N_COUNTERS = 4,
    localparam int unsigned N_REGS     = N_COUNTERS + 2,
    localparam int unsigned IDX_W      = $clog2(N_REGS)
) (
    input  wire                   clk_i,
    input  wire                   rstn_i,
    // AHB-lite slave side
    input  wire                   hsel_i,
    input  wire ahb_pkg::haddr_t  haddr_i,
    input  wire                   hwrite_i,
    input  wire ahb_pkg::htrans_e htrans_i,
    input  wire ahb_pkg::hdata_t  hwdata_i,
    input  wire                   hready_i,
    output logic                  hready_o,
    output logic                  hresp_o,
    output ahb_pkg::hdata_t       hrdata_o,
    // Register bank side
    output logic                  wr_en_o,
    output logic [IDX_W-1:0]      wr_idx_o,
    output pmu_pkg::word_t        wr_data_o,
    output logic [IDX_W-1:0]      rd_idx_o,
    input  wire pmu_pkg::word_t   rd_data_i
);

    // ------------------------------------------------------------------------
    // Address phase
    // ------------------------------------------------------------------------

    logic             accept;
    logic             in_range;
    logic             dp_valid_q;
    logic             dp_write_q;
    logic             dp_in_range_q;
    logic [IDX_W-1:0] dp_idx_q;

    // NONSEQ and SEQ are treated alike while IDLE and BUSY fall through
    assign accept = hsel_i && hready_i &&
                    ((htrans_i == ahb_pkg::HTRANS_NONSEQ) ||
                     (htrans_i == ahb_pkg::HTRANS_SEQ));

    // The whole word address is compared so that aliases above the map are out of range
    assign in_range = (haddr_i[ahb_pkg::HADDR_WIDTH-1:2] < (ahb_pkg::HADDR_WIDTH - 2)'(N_REGS));

    // Marks the data phase one cycle after an accepted transfer
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            dp_valid_q <= 1'b0;
        end else begin
            dp_valid_q <= accept;
        end
    end

    // Transfer attributes that matter only while dp_valid_q is high
    always_ff @(posedge clk_i) begin
        if (accept) begin
            dp_write_q    <= hwrite_i;
            dp_in_range_q <= in_range;
            dp_idx_q      <= haddr_i[IDX_W+1:2];
        end
    end

    // ------------------------------------------------------------------------
    // Data phase
    // ------------------------------------------------------------------------

    // One-cycle strobe with the write data taken straight from the bus
    assign wr_en_o   = dp_valid_q && dp_write_q && dp_in_range_q;
    assign wr_idx_o  = dp_idx_q;
    assign wr_data_o = hwdata_i;

    // Bank answers combinationally from the stored word
    assign rd_idx_o = dp_idx_q;
    assign hrdata_o = (dp_valid_q && !dp_write_q && dp_in_range_q) ? rd_data_i : '0;

    // Zero-wait slave that never signals an error
    assign hready_o = 1'b1;
    assign hresp_o  = ahb_pkg::HRESP_OKAY;

    // Completion is unconditional out of reset
    a_always_ready : assert property (@(posedge clk_i) disable iff (!rstn_i)
        hready_o && (hresp_o == ahb_pkg::HRESP_OKAY));

endmodule

`default_nettype wire

//--- hw/regbank/pmu_regbank.sv
// SEC-DED protected PMU register storage with bus write override and sticky fault interrupt
`default_nettype none

module pmu_regbank #(
    parameter  int unsigned N_COUNTERS = 4,
    localparam int unsigned N_REGS     = N_COUNTERS + 2,
    localparam int unsigned IDX_W      = $clog2(N_REGS)
) (
    input  wire                 clk_i,
    input  wire                 rstn_i,
    // Bus write strobe from the slave
    input  wire                 wr_en_i,
    input  wire [IDX_W-1:0]     wr_idx_i,
    input  wire pmu_pkg::word_t wr_data_i,
    // Bus read port
    input  wire [IDX_W-1:0]     rd_idx_i,
    output pmu_pkg::word_t      rd_data_o,
    // Counter core exchange
    output pmu_pkg::word_t      regs_o [N_REGS],
    input  wire pmu_pkg::word_t next_regs_i [N_REGS],
    // Uncorrectable error seen
    output logic                intr_ft_o
);

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    // One codeword per register
    pmu_pkg::code_t      ecc_mem   [N_REGS];
    pmu_pkg::code_t      next_code [N_REGS];
    // Correctable errors are repaired on decode and scrubbed by the next store
    logic [N_REGS-1:0]   err_single;
    logic [N_REGS-1:0]   err_double;
    logic                fault_q;

    // Core value for every index unless the bus strobes it
    always_comb begin
        for (int i = 0; i < N_REGS; i++) begin
            if (wr_en_i && (wr_idx_i == IDX_W'(i))) begin
                next_code[i] = pmu_pkg::ecc_encode(wr_data_i);
            end else begin
                next_code[i] = pmu_pkg::ecc_encode(next_regs_i[i]);
            end
        end
    end

    // Rewriting every word each cycle also scrubs single flips
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < N_REGS; i++) begin
                ecc_mem[i] <= pmu_pkg::ecc_encode('0);
            end
        end else begin
            ecc_mem <= next_code;
        end
    end

    // ------------------------------------------------------------------------
    // Decode and read
    // ------------------------------------------------------------------------

    // Corrected view of every stored word
    always_comb begin
        for (int i = 0; i < N_REGS; i++) begin
            regs_o[i] = pmu_pkg::ecc_decode(ecc_mem[i], err_single[i], err_double[i]);
        end
    end

    // Indices past the map are masked by the slave
    assign rd_data_o = regs_o[rd_idx_i];

    // ------------------------------------------------------------------------
    // Fault flag
    // ------------------------------------------------------------------------

    // Any word with a double error sets the flag until reset
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            fault_q <= 1'b0;
        end else begin
            fault_q <= fault_q | (|err_double);
        end
    end

    assign intr_ft_o = fault_q;

    // Strobes from the slave never point past the map
    a_wr_idx_range : assert property (@(posedge clk_i) disable iff (!rstn_i)
        wr_en_i |-> (32'(wr_idx_i) < N_REGS));

endmodule

`default_nettype wire

//--- hw/pmu_counters.sv
// PMU event counter core: next values for all registers each cycle and the overflow interrupt
`default_nettype none

module pmu_counters #(
    parameter  int unsigned N_COUNTERS = 4,
    localparam int unsigned N_REGS     = N_COUNTERS + 2,
    localparam int unsigned REG_OVF    = N_COUNTERS + 1
) (
    input  wire                    clk_i,
    input  wire                    rstn_i,
    input  wire pmu_pkg::word_t    regs_i [N_REGS],
    output pmu_pkg::word_t         next_regs_o [N_REGS],
    input  wire [N_COUNTERS-1:0]   events_i,
    output logic                   intr_overflow_o
);

    // ------------------------------------------------------------------------
    // Next register values
    // ------------------------------------------------------------------------

    pmu_pkg::pmu_cfg_u       cfg_cur;
    pmu_pkg::pmu_cfg_u       cfg_nxt;
    logic [N_COUNTERS-1:0]   wrap;
    pmu_pkg::word_t          status_nxt;
    logic                    ovf_q;

    always_comb begin
        // Configuration decoded through the union
        cfg_cur.raw = regs_i[pmu_pkg::REG_CFG];
        cfg_nxt     = cfg_cur;
        // Soft reset lasts a single cycle, enable is kept
        cfg_nxt.cfg.soft_rst = 1'b0;
        next_regs_o[pmu_pkg::REG_CFG] = cfg_nxt.raw;

        wrap = '0;
        for (int k = 0; k < N_COUNTERS; k++) begin
            if (cfg_cur.cfg.soft_rst) begin
                next_regs_o[pmu_pkg::REG_CNT_BASE + k] = '0;
            end else if (cfg_cur.cfg.enable && events_i[k]) begin
                next_regs_o[pmu_pkg::REG_CNT_BASE + k] = regs_i[pmu_pkg::REG_CNT_BASE + k] + 1'b1;
                // All ones rolls over to zero in this update
                wrap[k] = (regs_i[pmu_pkg::REG_CNT_BASE + k] == '1);
            end else begin
                next_regs_o[pmu_pkg::REG_CNT_BASE + k] = regs_i[pmu_pkg::REG_CNT_BASE + k];
            end
        end

        // Status bits are sticky, cleared by soft reset or a bus write
        if (cfg_cur.cfg.soft_rst) begin
            status_nxt = '0;
        end else begin
            status_nxt = regs_i[REG_OVF] | pmu_pkg::word_t'(wrap);
        end
        next_regs_o[REG_OVF] = status_nxt;
    end

    // ------------------------------------------------------------------------
    // Overflow interrupt
    // ------------------------------------------------------------------------

    // Registered alongside the status word it is derived from
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ovf_q <= 1'b0;
        end else begin
            ovf_q <= |status_nxt[N_COUNTERS-1:0];
        end
    end

    assign intr_overflow_o = ovf_q;

    // A status bit set by the core always comes from a counter at all ones
    for (genvar k = 0; k < N_COUNTERS; k++) begin : g_ovf_chk
        a_ovf_source : assert property (@(posedge clk_i) disable iff (!rstn_i)
            ($rose(regs_i[REG_OVF][k]) && $past(next_regs_o[REG_OVF][k]))
            |-> ($past(regs_i[pmu_pkg::REG_CNT_BASE + k]) == '1));
    end

endmodule

`default_nettype wire

//--- hw/pmu_top.sv
// PMU top level: joins the AHB-lite slave, the protected register bank and the counter core
`default_nettype none

module pmu_top #(
    parameter  int unsigned N_COUNTERS = 4,
    localparam int unsigned N_REGS     = N_COUNTERS + 2,
    localparam int unsigned IDX_W      = $clog2(N_REGS)
) (
    input  wire                   clk_i,
    input  wire                   rstn_i,
    // AHB-lite slave port
    input  wire                   hsel_i,
    input  wire ahb_pkg::haddr_t  haddr_i,
    input  wire                   hwrite_i,
    input  wire ahb_pkg::htrans_e htrans_i,
    input  wire ahb_pkg::hdata_t  hwdata_i,
    input  wire                   hready_i,
    output logic                  hready_o,
    output logic                  hresp_o,
    output ahb_pkg::hdata_t       hrdata_o,
    // SoC events and interrupts
    input  wire [N_COUNTERS-1:0]  events_i,
    output logic                  intr_overflow_o,
    output logic                  intr_ft_o
);

    // ------------------------------------------------------------------------
    // Internal connections
    // ------------------------------------------------------------------------

    // Slave to bank
    logic             wr_en;
    logic [IDX_W-1:0] wr_idx;
    pmu_pkg::word_t   wr_data;
    logic [IDX_W-1:0] rd_idx;
    pmu_pkg::word_t   rd_data;

    // Bank to core and back
    pmu_pkg::word_t   regs      [N_REGS];
    pmu_pkg::word_t   next_regs [N_REGS];

    pmu_ahb_slave #(
        .N_COUNTERS (N_COUNTERS)
    ) u_ahb_slave (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .hsel_i    (hsel_i),
        .haddr_i   (haddr_i),
        .hwrite_i  (hwrite_i),
        .htrans_i  (htrans_i),
        .hwdata_i  (hwdata_i),
        .hready_i  (hready_i),
        .hready_o  (hready_o),
        .hresp_o   (hresp_o),
        .hrdata_o  (hrdata_o),
        .wr_en_o   (wr_en),
        .wr_idx_o  (wr_idx),
        .wr_data_o (wr_data),
        .rd_idx_o  (rd_idx),
        .rd_data_i (rd_data)
    );

    pmu_regbank #(
        .N_COUNTERS (N_COUNTERS)
    ) u_regbank (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .wr_en_i     (wr_en),
        .wr_idx_i    (wr_idx),
        .wr_data_i   (wr_data),
        .rd_idx_i    (rd_idx),
        .rd_data_o   (rd_data),
        .regs_o      (regs),
        .next_regs_i (next_regs),
        .intr_ft_o   (intr_ft_o)
    );

    pmu_counters #(
        .N_COUNTERS (N_COUNTERS)
    ) u_counters (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .regs_i          (regs),
        .next_regs_o     (next_regs),
        .events_i        (events_i),
        .intr_overflow_o (intr_overflow_o)
    );

endmodule

`default_nettype wire

//--- sim/tb_pmu_tasks.svh
// AHB-lite access, wait and compare tasks of the PMU testbench, included inside its top module
`ifndef TB_PMU_TASKS_SVH
`define TB_PMU_TASKS_SVH

// Word index to byte address
function automatic ahb_pkg::haddr_t reg_addr(input int unsigned idx);
    return ahb_pkg::haddr_t'(idx) << 2;
endfunction

// ----------------------------------------------------------------------------
// Waits, each bounded by TIMEOUT falling edges
// ----------------------------------------------------------------------------

task automatic wait_ready();
    int n;
    n = 0;
    while ((hready_o !== 1'b1) && (n < TIMEOUT)) begin
        @(negedge clk_i);
        n++;
    end
    if (hready_o !== 1'b1) begin
        stop_on_timeout("hready_o high");
    end
endtask

// ft selects intr_ft_o, otherwise intr_overflow_o
task automatic wait_intr(input logic ft, input logic level, input string what);
    int n;
    n = 0;
    while (((ft ? intr_ft_o : intr_overflow_o) !== level) && (n < TIMEOUT)) begin
        @(negedge clk_i);
        n++;
    end
    if ((ft ? intr_ft_o : intr_overflow_o) !== level) begin
        stop_on_timeout(what);
    end
endtask

// ----------------------------------------------------------------------------
// Single transfers, started and ended on a falling edge
// ----------------------------------------------------------------------------

task automatic ahb_write(input ahb_pkg::haddr_t addr, input ahb_pkg::hdata_t data);
    wait_ready();
    hsel_i   = 1'b1;
    haddr_i  = addr;
    hwrite_i = 1'b1;
    htrans_i = ahb_pkg::HTRANS_NONSEQ;
    @(negedge clk_i);
    // Data phase, write data follows one cycle after the address
    hwdata_i = data;
    hsel_i   = 1'b0;
    hwrite_i = 1'b0;
    htrans_i = ahb_pkg::HTRANS_IDLE;
    @(negedge clk_i);
endtask

task automatic ahb_read(input ahb_pkg::haddr_t addr, output pmu_pkg::word_t data);
    wait_ready();
    hsel_i   = 1'b1;
    haddr_i  = addr;
    hwrite_i = 1'b0;
    htrans_i = ahb_pkg::HTRANS_NONSEQ;
    @(negedge clk_i);
    hsel_i   = 1'b0;
    htrans_i = ahb_pkg::HTRANS_IDLE;
    // Middle of the data phase
    data = hrdata_o;
endtask

// ----------------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------------

task automatic check_word(input string name, input pmu_pkg::word_t exp, input pmu_pkg::word_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_cfg(input string name, input pmu_pkg::pmu_cfg_u exp,
                         input pmu_pkg::pmu_cfg_u act);
    check_count++;
    if (act.raw !== exp.raw) begin
        error_count++;
        $display("Fail %s: expected %h (enable %b soft_rst %b), actual %h (enable %b soft_rst %b)",
                 name, exp.raw, exp.cfg.enable, exp.cfg.soft_rst,
                 act.raw, act.cfg.enable, act.cfg.soft_rst);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("Fail %s: expected %b, actual %b", name, exp, act);
    end
endtask

`endif

//--- sim/tb_pmu_top.sv
// Directed testbench of the PMU top level; compile with files.f, runs every test and prints a summary
`default_nettype none

module tb_pmu_top;

    // ------------------------------------------------------------------------
    // Parameters and DUT signals
    // ------------------------------------------------------------------------

    localparam int unsigned N_COUNTERS   = 4;
    localparam int unsigned N_REGS       = N_COUNTERS + 2;
    localparam int unsigned REG_OVF      = N_COUNTERS + 1;
    localparam int          CLK_PERIOD   = 100;
    localparam int          TIMEOUT      = 50;
    localparam int          COUNT_CYCLES = 40;

    logic                  clk_i;
    logic                  rstn_i;
    logic                  hsel_i;
    ahb_pkg::haddr_t       haddr_i;
    logic                  hwrite_i;
    ahb_pkg::htrans_e      htrans_i;
    ahb_pkg::hdata_t       hwdata_i;
    logic                  hready_i;
    logic                  hready_o;
    logic                  hresp_o;
    ahb_pkg::hdata_t       hrdata_o;
    logic [N_COUNTERS-1:0] events_i;
    logic                  intr_overflow_o;
    logic                  intr_ft_o;

    // test_errors holds the error count at the start of the running test
    int          error_count;
    int          check_count;
    int          test_count;
    int          test_errors;
    logic [15:0] lfsr_q;

    pmu_top #(
        .N_COUNTERS (N_COUNTERS)
    ) u_pmu_top (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .hsel_i          (hsel_i),
        .haddr_i         (haddr_i),
        .hwrite_i        (hwrite_i),
        .htrans_i        (htrans_i),
        .hwdata_i        (hwdata_i),
        .hready_i        (hready_i),
        .hready_o        (hready_o),
        .hresp_o         (hresp_o),
        .hrdata_o        (hrdata_o),
        .events_i        (events_i),
        .intr_overflow_o (intr_overflow_o),
        .intr_ft_o       (intr_ft_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    `include "tb_pmu_tasks.svh"

    // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1 and output in bit 0
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // Holds reset low over four rising edges and releases it on a falling edge
    task automatic apply_reset();
        rstn_i = 1'b0;
        repeat (4) @(negedge clk_i);
        rstn_i = 1'b1;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == test_errors) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    task automatic test_reset_state();
        pmu_pkg::word_t rd;
        for (int i = 0; i < N_REGS; i++) begin
            ahb_read(reg_addr(i), rd);
            check_word($sformatf("reset reg %0d", i), '0, rd);
        end
        check_bit("reset intr_overflow_o", 1'b0, intr_overflow_o);
        check_bit("reset intr_ft_o", 1'b0, intr_ft_o);
        check_bit("reset hready_o", 1'b1, hready_o);
        check_bit("reset hresp_o", ahb_pkg::HRESP_OKAY, hresp_o);
        end_test("reset_state");
    endtask

    task automatic test_register_access();
        pmu_pkg::word_t rd;
        pmu_pkg::word_t exp [N_REGS];
        // Low two bits clear, so the configuration word neither counts nor resets
        for (int i = 0; i < N_REGS; i++) begin
            exp[i] = 32'h1357_9BDC + (i << 12);
            ahb_write(reg_addr(i), exp[i]);
        end
        for (int i = 0; i < N_REGS; i++) begin
            ahb_read(reg_addr(i), rd);
            check_word($sformatf("readback reg %0d", i), exp[i], rd);
        end
        ahb_read(reg_addr(N_REGS), rd);
        check_word("out of range read", '0, rd);
        ahb_write(reg_addr(N_REGS), 32'hDEAD_BEEC);
        // High alias whose low index bits point at the configuration word
        ahb_write(32'h0000_1000, 32'hDEAD_BEEC);
        for (int i = 0; i < N_REGS; i++) begin
            ahb_read(reg_addr(i), rd);
            check_word($sformatf("after out of range write reg %0d", i), exp[i], rd);
        end
        for (int i = 0; i < N_REGS; i++) begin
            ahb_write(reg_addr(i), '0);
        end
        end_test("register_access");
    endtask

    task automatic test_counting();
        logic [N_COUNTERS-1:0] ev;
        pmu_pkg::word_t        exp_cnt [N_COUNTERS];
        pmu_pkg::word_t        rd;
        for (int k = 0; k < N_COUNTERS; k++) begin
            exp_cnt[k] = '0;
        end
        ahb_write(reg_addr(pmu_pkg::REG_CFG), 32'h1);
        // Each event bit takes one LFSR step and counts on the next rising edge
        repeat (COUNT_CYCLES) begin
            for (int k = 0; k < N_COUNTERS; k++) begin
                ev[k]  = lfsr_q[0];
                lfsr_q = lfsr_next(lfsr_q);
                if (ev[k]) begin
                    exp_cnt[k] = exp_cnt[k] + 1;
                end
            end
            events_i = ev;
            @(negedge clk_i);
        end
        events_i = '0;
        ahb_write(reg_addr(pmu_pkg::REG_CFG), 32'h0);
        for (int k = 0; k < N_COUNTERS; k++) begin
            ahb_read(reg_addr(pmu_pkg::REG_CNT_BASE + k), rd);
            check_word($sformatf("count of counter %0d", k), exp_cnt[k], rd);
        end
        end_test("counting");
    endtask

    task automatic test_overflow();
        pmu_pkg::word_t rd;
        ahb_write(reg_addr(pmu_pkg::REG_CNT_BASE), 32'hFFFF_FFFD);
        ahb_write(reg_addr(pmu_pkg::REG_CFG), 32'h1);
        // Three events take the counter through all ones to zero
        events_i = N_COUNTERS'(1);
        repeat (3) @(negedge clk_i);
        events_i = '0;
        check_bit("overflow interrupt raised", 1'b1, intr_overflow_o);
        ahb_write(reg_addr(pmu_pkg::REG_CFG), 32'h0);
        ahb_read(reg_addr(pmu_pkg::REG_CNT_BASE), rd);
        check_word("counter after wrap", '0, rd);
        ahb_read(reg_addr(REG_OVF), rd);
        check_word("status after wrap", 32'h1, rd);
        ahb_write(reg_addr(REG_OVF), 32'h0);
        wait_intr(1'b0, 1'b0, "overflow interrupt clear");
        ahb_read(reg_addr(REG_OVF), rd);
        check_word("status after clear", '0, rd);
        end_test("overflow");
    endtask

    task automatic test_soft_reset();
        pmu_pkg::word_t    rd;
        pmu_pkg::pmu_cfg_u exp_cfg;
        pmu_pkg::pmu_cfg_u act_cfg;
        exp_cfg.raw        = '0;
        exp_cfg.cfg.enable = 1'b1;
        for (int k = 0; k < N_COUNTERS; k++) begin
            ahb_write(reg_addr(pmu_pkg::REG_CNT_BASE + k), 32'h100 + k);
        end
        ahb_write(reg_addr(REG_OVF), 32'h5);
        // soft_rst plus enable in one write
        ahb_write(reg_addr(pmu_pkg::REG_CFG), 32'h3);
        ahb_read(reg_addr(pmu_pkg::REG_CFG), rd);
        act_cfg.raw = rd;
        check_cfg("config after soft reset", exp_cfg, act_cfg);
        for (int k = 0; k < N_COUNTERS; k++) begin
            ahb_read(reg_addr(pmu_pkg::REG_CNT_BASE + k), rd);
            check_word($sformatf("counter %0d after soft reset", k), '0, rd);
        end
        ahb_read(reg_addr(REG_OVF), rd);
        check_word("status after soft reset", '0, rd);
        wait_intr(1'b0, 1'b0, "overflow interrupt clear after soft reset");
        ahb_write(reg_addr(pmu_pkg::REG_CFG), 32'h0);
        end_test("soft_reset");
    endtask

    task automatic test_ecc();
        pmu_pkg::word_t    rd;
        pmu_pkg::pmu_cfg_u exp_cfg;
        pmu_pkg::pmu_cfg_u act_cfg;
        exp_cfg.raw = 32'hA5A5_0000;
        ahb_write(reg_addr(pmu_pkg::REG_CFG), exp_cfg.raw);
        // Single flip at a data position of the stored codeword
        u_pmu_top.u_regbank.ecc_mem[pmu_pkg::REG_CFG][5] =
            ~u_pmu_top.u_regbank.ecc_mem[pmu_pkg::REG_CFG][5];
        ahb_read(reg_addr(pmu_pkg::REG_CFG), rd);
        act_cfg.raw = rd;
        check_cfg("config after single flip", exp_cfg, act_cfg);
        check_bit("no fault on single flip", 1'b0, intr_ft_o);
        // Two flips in the same word cannot be corrected
        u_pmu_top.u_regbank.ecc_mem[pmu_pkg::REG_CFG][5] =
            ~u_pmu_top.u_regbank.ecc_mem[pmu_pkg::REG_CFG][5];
        u_pmu_top.u_regbank.ecc_mem[pmu_pkg::REG_CFG][9] =
            ~u_pmu_top.u_regbank.ecc_mem[pmu_pkg::REG_CFG][9];
        wait_intr(1'b1, 1'b1, "fault interrupt");
        repeat (5) @(negedge clk_i);
        check_bit("fault stays set", 1'b1, intr_ft_o);
        apply_reset();
        check_bit("fault cleared by reset", 1'b0, intr_ft_o);
        end_test("ecc");
    endtask

    // ------------------------------------------------------------------------
    // Sequence
    // ------------------------------------------------------------------------

    initial begin
        clk_i       = 1'b0;
        rstn_i      = 1'b0;
        hsel_i      = 1'b0;
        haddr_i     = '0;
        hwrite_i    = 1'b0;
        htrans_i    = ahb_pkg::HTRANS_IDLE;
        hwdata_i    = '0;
        hready_i    = 1'b1;
        events_i    = '0;
        lfsr_q      = 16'd33270;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        test_errors = 0;
        apply_reset();
        test_reset_state();
        test_register_access();
        test_counting();
        test_overflow();
        test_soft_reset();
        test_ecc();
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+sim
common/ahb_pkg.sv
common/pmu_pkg.sv
hw/ahb_slave/pmu_ahb_slave.sv
hw/regbank/pmu_regbank.sv
hw/pmu_counters.sv
hw/pmu_top.sv
sim/tb_pmu_top.sv

//--- Bender.yml
package:
  name: pmu_ahb

sources:
  - common/ahb_pkg.sv
  - common/pmu_pkg.sv
  - hw/ahb_slave/pmu_ahb_slave.sv
  - hw/regbank/pmu_regbank.sv
  - hw/pmu_counters.sv
  - hw/pmu_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_pmu_top.sv
